//--- flist.f
uart_pkg.sv
uart_baud_gen.sv
uart_fifo.sv
uart_tx.sv
uart_rx.sv
uart_events.sv
uart_top.sv
tb_clock.sv
tb_uart.sv

//--- run.sh
#!/bin/sh
# build with Verilator and run, pass is decided by the pass message
verilator --binary --timing --assert -f flist.f --top-module tb_uart \
  && ./obj_dir/Vtb_uart | tee /dev/stderr | grep "All tests passed!" > /dev/null \
  && echo "simulation ok" \
  || { echo "simulation failed"; exit 1; }

//--- tb_clock.sv
/*
  Clock and reset source for the UART testbench.
  Reset is held low for 3 rising edges and released on a falling edge.
*/
`timescale 1ns/10ps

module tb_clock #(
  parameter int PeriodNs = 100
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (3) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

//--- tb_uart.sv
/*
  Directed testbench for the UART core. nco 0x8000 gives 32 cycles per bit.
  rx_i is either looped back from tx_o or driven by the frame injector.
  Inputs change on the falling edge and events are counted there as well.
  The injected frames assume parity is enabled and so carry 11 bits.
*/
`timescale 1ns/10ps

module tb_uart import uart_pkg::*; ();

  localparam int BitCycles     = 32;
  localparam int TimeoutCycles = 60 * 11 * BitCycles + 2000;

  logic                 clk, rst_n;
  uart_cfg_t            cfg;
  logic                 tx_we, rx_re, rx_line, loop_en, tx_line;
  logic [DataWidth-1:0] tx_wdata, rx_rdata;
  uart_status_t         status;
  uart_events_t         events;

  int          errors;
  int          cycles;
  int          n_wm, n_ovf, n_ferr, n_perr, n_txe;
  logic [31:0] rng;
  logic [7:0]  exp_q[$];

  tb_clock u_clock (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  uart_top #(.FifoDepth(16)) DUT (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .cfg_i      (cfg),
    .tx_we_i    (tx_we),
    .tx_wdata_i (tx_wdata),
    .rx_re_i    (rx_re),
    .rx_i       (loop_en ? tx_line : rx_line),
    .tx_o       (tx_line),
    .rx_rdata_o (rx_rdata),
    .status_o   (status),
    .events_o   (events)
  );

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TimeoutCycles) begin
      $display("timeout, the tests were still running after %0d cycles", cycles);
      $display("Test failures found");
      $finish;
    end
  end

  // event pulses are stable mid-cycle
  always @(negedge clk) begin
    if (rst_n) begin
      if (events.rx_watermark)  n_wm   <= n_wm + 1;
      if (events.rx_overflow)   n_ovf  <= n_ovf + 1;
      if (events.rx_frame_err)  n_ferr <= n_ferr + 1;
      if (events.rx_parity_err) n_perr <= n_perr + 1;
      if (events.tx_empty)      n_txe  <= n_txe + 1;
    end
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic set_config(input logic par_en, input logic par_odd, input logic nf_en,
                            input uart_rxilvl_e lvl);
    @(negedge clk);
    cfg.tx_en      = 1'b1;
    cfg.rx_en      = 1'b1;
    cfg.nf_en      = nf_en;
    cfg.parity_en  = par_en;
    cfg.parity_odd = par_odd;
    cfg.nco        = 16'h8000;
    cfg.rxilvl     = lvl;
  endtask

  task automatic write_byte(input logic [7:0] b);
    while (status.tx_full) @(negedge clk);
    tx_wdata = b;
    tx_we    = 1'b1;
    @(negedge clk);
    tx_we    = 1'b0;
  endtask

  // pops n entries one per cycle and checks them against the expected queue
  task automatic read_expected(input int n);
    for (int i = 0; i < n; i++) begin
      check_value("status_o.rx_empty", 32'(status.rx_empty), 32'd0);
      check_value("rx_rdata_o", 32'(rx_rdata), 32'(exp_q.pop_front()));
      rx_re = 1'b1;
      @(negedge clk);
    end
    rx_re = 1'b0;
  endtask

  // frame of start, 8 data bits lsb first, parity and stop, then two idle bits
  task automatic drive_frame(input logic [7:0] data, input logic par_bit,
                             input logic stop_bit);
    logic [10:0] bits;
    bits = {stop_bit, par_bit, data, 1'b0};
    for (int i = 0; i < 11; i++) begin
      rx_line = bits[i];
      wait_cycles(BitCycles);
    end
    rx_line = 1'b1;
    wait_cycles(2 * BitCycles);
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////
  task automatic reset_state_test();
    check_value("tx_o", 32'(tx_line), 32'd1);
    check_value("status_o.tx_empty", 32'(status.tx_empty), 32'd1);
    check_value("status_o.rx_empty", 32'(status.rx_empty), 32'd1);
    check_value("status_o.tx_full", 32'(status.tx_full), 32'd0);
    check_value("status_o.rx_full", 32'(status.rx_full), 32'd0);
    check_value("status_o.tx_idle", 32'(status.tx_idle), 32'd1);
    check_value("status_o.rx_idle", 32'(status.rx_idle), 32'd1);
    check_value("status_o.tx_lvl", 32'(status.tx_lvl), 32'd0);
    check_value("status_o.rx_lvl", 32'(status.rx_lvl), 32'd0);
    check_value("events_o", 32'(events), 32'd0);
  endtask

  task automatic loopback_test(input int n, input logic par_en, input logic par_odd,
                               input logic nf_en);
    int         txe0;
    logic [7:0] b;
    set_config(par_en, par_odd, nf_en, RXLVL_1);
    exp_q.delete();
    loop_en = 1'b1;
    txe0    = n_txe;
    for (int i = 0; i < n; i++) begin
      rng = xorshift32(rng);
      b   = rng[7:0];
      exp_q.push_back(b);
      write_byte(b);
    end
    while (int'(status.rx_lvl) < n) @(negedge clk);
    // the last stop bit ends after the last push
    while (!status.tx_idle) @(negedge clk);
    @(negedge clk);
    check_value("events_o.tx_empty count", 32'(n_txe - txe0), 32'd1);
    read_expected(n);
    check_value("status_o.rx_lvl", 32'(status.rx_lvl), 32'd0);
  endtask

  // the rx FIFO was drained by the previous test, so it stays empty here
  task automatic injected_error_test();
    logic [7:0] b;
    int         perr0, ferr0;
    set_config(1'b1, 1'b0, 1'b0, RXLVL_1);
    rx_line = 1'b1;
    loop_en = 1'b0;
    wait_cycles(BitCycles);
    perr0 = n_perr;
    ferr0 = n_ferr;
    rng   = xorshift32(rng);
    b     = rng[7:0];
    // even parity bit inverted
    drive_frame(b, ~(^b), 1'b1);
    check_value("events_o.rx_parity_err count", 32'(n_perr - perr0), 32'd1);
    check_value("events_o.rx_frame_err count", 32'(n_ferr - ferr0), 32'd0);
    check_value("status_o.rx_lvl", 32'(status.rx_lvl), 32'd0);
    drive_frame(b, ^b, 1'b0);
    check_value("events_o.rx_frame_err count", 32'(n_ferr - ferr0), 32'd1);
    check_value("events_o.rx_parity_err count", 32'(n_perr - perr0), 32'd1);
    check_value("status_o.rx_lvl", 32'(status.rx_lvl), 32'd0);
    loop_en = 1'b1;
  endtask

  task automatic watermark_overflow_test();
    int         wm0, ovf0;
    logic [7:0] b;
    set_config(1'b0, 1'b0, 1'b0, RXLVL_4);
    exp_q.delete();
    loop_en = 1'b1;
    wm0     = n_wm;
    ovf0    = n_ovf;
    for (int i = 0; i < 17; i++) begin
      rng = xorshift32(rng);
      b   = rng[7:0];
      exp_q.push_back(b);
      write_byte(b);
    end
    while (n_ovf == ovf0) @(negedge clk);
    while (!status.tx_idle) @(negedge clk);
    @(negedge clk);
    check_value("events_o.rx_watermark count", 32'(n_wm - wm0), 32'd1);
    check_value("events_o.rx_overflow count", 32'(n_ovf - ovf0), 32'd1);
    check_value("status_o.rx_full", 32'(status.rx_full), 32'd1);
    check_value("status_o.rx_lvl", 32'(status.rx_lvl), 32'd16);
    // the 17th byte was lost at the full rx FIFO
    void'(exp_q.pop_back());
    read_expected(16);
  endtask

  initial begin
    errors   = 0;
    rng      = 32'd19024;
    cfg      = '0;
    cfg.tx_en  = 1'b1;
    cfg.rx_en  = 1'b1;
    cfg.nco    = 16'h8000;
    cfg.rxilvl = RXLVL_1;
    tx_we    = 1'b0;
    tx_wdata = '0;
    rx_re    = 1'b0;
    rx_line  = 1'b1;
    loop_en  = 1'b1;
    wait (rst_n === 1'b1);
    @(negedge clk);
    reset_state_test();
    loopback_test(8, 1'b0, 1'b0, 1'b0);
    loopback_test(8, 1'b1, 1'b0, 1'b1);
    loopback_test(8, 1'b1, 1'b1, 1'b1);
    injected_error_test();
    watermark_overflow_test();
    $display("tests done, %0d errors in %0d cycles", errors, cycles);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- uart_baud_gen.sv
/*
  NCO baud generator, tick rate is f_clk * nco / 2**NcoWidth.
  The tick is the registered carry and is high for one cycle.
  nco values above half range give ticks on back-to-back cycles.
*/
`timescale 1ns/10ps

module uart_baud_gen import uart_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                enable_i,
  input  logic [NcoWidth-1:0] nco_i,
  output logic                tick_x16_o
);

  // top bit holds the carry out of the previous add
  logic [NcoWidth:0] acc_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q <= '0;
    end else if (enable_i) begin
      acc_q <= {1'b0, acc_q[NcoWidth-1:0]} + {1'b0, nco_i};
    end else begin
      // drop a pending carry so no tick leaks out while disabled
      acc_q <= {1'b0, acc_q[NcoWidth-1:0]};
    end
  end

  assign tick_x16_o = acc_q[NcoWidth];

endmodule

//--- uart_events.sv
/*
  Event pulses for the UART core, each one cycle wide.
  rx_watermark is registered, one cycle after the level first meets the
  threshold. tx_empty fires on the busy-to-idle edge of the serializer
  only while the tx FIFO is empty, so refilling in time suppresses it.
*/
`timescale 1ns/10ps

module uart_events import uart_pkg::*; #(
  parameter int FifoDepth = 16
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  uart_rxilvl_e                     rxilvl_i,
  input  logic [$clog2(FifoDepth+1)-1:0]   rx_depth_i,
  input  logic                             rx_push_i,
  input  logic                             rx_wready_i,
  input  logic                             rx_frame_err_i,
  input  logic                             rx_parity_err_i,
  input  logic                             tx_idle_i,
  input  logic                             tx_fifo_rvalid_i,
  output uart_events_t                     events_o
);

  int unsigned thr;
  logic        thr_en;
  logic        wm_d, wm_prev_q, wm_pulse_q;
  logic        tx_idle_q;

  always_comb begin
    thr_en = 1'b1;
    unique case (rxilvl_i)
      RXLVL_1:  thr = 1;
      RXLVL_4:  thr = 4;
      RXLVL_8:  thr = 8;
      RXLVL_16: thr = 16;
      default: begin
        thr    = 0;
        thr_en = 1'b0;
      end
    endcase
    wm_d = thr_en & (32'(rx_depth_i) >= thr);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wm_prev_q  <= 1'b0;
      wm_pulse_q <= 1'b0;
      tx_idle_q  <= 1'b1;
    end else begin
      wm_prev_q  <= wm_d;
      wm_pulse_q <= wm_d & ~wm_prev_q;
      tx_idle_q  <= tx_idle_i;
    end
  end

  assign events_o.rx_watermark  = wm_pulse_q;
  assign events_o.rx_overflow   = rx_push_i & ~rx_wready_i;
  assign events_o.rx_frame_err  = rx_frame_err_i;
  assign events_o.rx_parity_err = rx_parity_err_i;
  assign events_o.tx_empty      = tx_idle_i & ~tx_idle_q & ~tx_fifo_rvalid_i;

  // an overflow can only come from a FIFO that holds FifoDepth entries
  a_overflow_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    events_o.rx_overflow |-> (32'(rx_depth_i) == FifoDepth));

endmodule

//--- uart_fifo.sv
/*
  Synchronous FIFO with first-word fall through on the read side.
  Writes while full and reads while empty are ignored.
  depth_o updates one cycle after the accepted write or read.
  Depth need not be a power of two.
*/
`timescale 1ns/10ps

module uart_fifo #(
  parameter int Width = 8,
  parameter int Depth = 16
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         wvalid_i,
  input  logic [Width-1:0]             wdata_i,
  input  logic                         rready_i,
  output logic                         wready_o,
  output logic [$clog2(Depth+1)-1:0]   depth_o,
  output logic                         rvalid_o,
  output logic [Width-1:0]             rdata_o
);

  localparam int DepthW = $clog2(Depth + 1);
  localparam int PtrW   = (Depth > 1) ? $clog2(Depth) : 1;

  logic [Width-1:0]  mem_q [Depth];
  logic [PtrW-1:0]   wptr_q, rptr_q;
  logic [DepthW-1:0] count_q;
  logic              do_write, do_read;

  function automatic logic [PtrW-1:0] ptr_inc(input logic [PtrW-1:0] ptr);
    if (ptr == PtrW'(Depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign wready_o = (count_q != DepthW'(Depth));
  assign rvalid_o = (count_q != '0);
  assign do_write = wvalid_i & wready_o;
  assign do_read  = rready_i & rvalid_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (do_write) wptr_q <= ptr_inc(wptr_q);
      if (do_read)  rptr_q <= ptr_inc(rptr_q);
      unique case ({do_write, do_read})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (do_write) mem_q[wptr_q] <= wdata_i;
  end

  assign rdata_o = mem_q[rptr_q];
  assign depth_o = count_q;

  a_count_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    count_q <= DepthW'(Depth));

endmodule

//--- uart_pkg.sv
/*
  Shared widths, configuration, status and event types for the UART core.
  cfg fields are expected to stay stable while a frame is in flight.
  Status levels are 6 bits wide, so FifoDepth must not exceed 63.
  Watermark codes other than the four listed disable the rx watermark.
*/
package uart_pkg;

  // nco accumulator and character width
  parameter int NcoWidth  = 16;
  parameter int DataWidth = 8;

  // rx watermark thresholds of 1, 4, 8 and 16 entries
  typedef enum logic [2:0] {
    RXLVL_1  = 3'd0,
    RXLVL_4  = 3'd1,
    RXLVL_8  = 3'd2,
    RXLVL_16 = 3'd3
  } uart_rxilvl_e;

  // bit phase, used by both serializer and deserializer
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_START,
    ST_DATA,
    ST_PARITY,
    ST_STOP
  } uart_bit_state_e;

  typedef struct packed {
    logic                tx_en;
    logic                rx_en;
    logic                nf_en;
    logic                parity_en;
    logic                parity_odd;
    logic [NcoWidth-1:0] nco;
    uart_rxilvl_e        rxilvl;
  } uart_cfg_t;

  typedef struct packed {
    logic       tx_full;
    logic       tx_empty;
    logic       tx_idle;
    logic       rx_full;
    logic       rx_empty;
    logic       rx_idle;
    logic [5:0] tx_lvl;
    logic [5:0] rx_lvl;
  } uart_status_t;

  // one-cycle pulses
  typedef struct packed {
    logic rx_watermark;
    logic rx_overflow;
    logic rx_frame_err;
    logic rx_parity_err;
    logic tx_empty;
  } uart_events_t;

endpackage

//--- uart_rx.sv
/*
  Receive path with a 2-flop synchronizer, an optional majority-of-3 filter
  and a deserializer that samples each bit 16 ticks apart, starting mid-bit.
  The filter adds 2 cycles of delay to the line.
  A frame starts only on a falling edge, so a stuck-low line after a
  frame error does not retrigger. Results pulse at the stop-bit sample.
*/
`timescale 1ns/10ps

module uart_rx import uart_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 rx_en_i,
  input  logic                 nf_en_i,
  input  logic                 tick_x16_i,
  input  logic                 parity_en_i,
  input  logic                 parity_odd_i,
  input  logic                 rx_i,
  output logic                 valid_o,
  output logic [DataWidth-1:0] data_o,
  output logic                 frame_err_o,
  output logic                 parity_err_o,
  output logic                 push_o,
  output logic                 idle_o
);

  logic                 sync_q1, sync_q2;
  logic                 nf_q1, nf_q2, nf_maj_q;
  logic                 rx_in, rx_prev_q, rx_fall;
  uart_bit_state_e      state_q;
  logic [3:0]           cnt_q;
  logic [2:0]           bit_q;
  logic [DataWidth-1:0] shift_q;
  logic                 par_bit_q;
  logic                 sample;

  ////////////////////////////////////////
  // line conditioning
  ////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sync_q1   <= 1'b1;
      sync_q2   <= 1'b1;
      nf_q1     <= 1'b1;
      nf_q2     <= 1'b1;
      nf_maj_q  <= 1'b1;
      rx_prev_q <= 1'b1;
    end else begin
      sync_q1   <= rx_i;
      sync_q2   <= sync_q1;
      nf_q1     <= sync_q2;
      nf_q2     <= nf_q1;
      // majority of 3 votes masks a one-cycle spike
      nf_maj_q  <= (sync_q2 & nf_q1) | (sync_q2 & nf_q2) | (nf_q1 & nf_q2);
      rx_prev_q <= rx_in;
    end
  end

  assign rx_in   = nf_en_i ? nf_maj_q : sync_q2;
  assign rx_fall = rx_prev_q & ~rx_in;
  assign sample  = tick_x16_i & (cnt_q == 4'hf);

  ////////////////////////////////////////
  // deserializer fsm
  ////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
      bit_q   <= '0;
    end else if (!rx_en_i) begin
      state_q <= ST_IDLE;
    end else begin
      if (state_q != ST_IDLE && tick_x16_i) cnt_q <= cnt_q + 4'd1;
      unique case (state_q)
        ST_IDLE: begin
          if (rx_fall) begin
            state_q <= ST_START;
            cnt_q   <= '0;
          end
        end
        ST_START: begin
          // a high line at mid start bit means it was a glitch
          if (tick_x16_i && cnt_q == 4'd7) begin
            state_q <= rx_in ? ST_IDLE : ST_DATA;
            cnt_q   <= '0;
            bit_q   <= '0;
          end
        end
        ST_DATA: begin
          if (sample) begin
            bit_q <= bit_q + 3'd1;
            if (bit_q == 3'd7) state_q <= parity_en_i ? ST_PARITY : ST_STOP;
          end
        end
        ST_PARITY: begin
          if (sample) state_q <= ST_STOP;
        end
        ST_STOP: begin
          if (sample) state_q <= ST_IDLE;
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == ST_DATA && sample) shift_q <= {rx_in, shift_q[DataWidth-1:1]};
    if (state_q == ST_PARITY && sample) par_bit_q <= rx_in;
  end

  // all results pulse in the stop-bit sample cycle
  assign valid_o      = rx_en_i & (state_q == ST_STOP) & sample;
  assign data_o       = shift_q;
  assign frame_err_o  = valid_o & ~rx_in;
  assign parity_err_o = valid_o & parity_en_i & ((^shift_q) ^ par_bit_q ^ parity_odd_i);
  assign push_o       = valid_o & ~frame_err_o & ~parity_err_o;
  assign idle_o       = (state_q == ST_IDLE);

endmodule

//--- uart_top.sv
/*
  UART core top: baud generator, tx and rx FIFOs, serializer,
  deserializer and event logic, driven by plain strobes and levels.
  A tx write into a full FIFO is dropped without notice.
  An rx byte arriving at a full FIFO is dropped and raises rx_overflow.
  rx_rdata_o is valid while status_o.rx_empty is low.
*/
`timescale 1ns/10ps

module uart_top import uart_pkg::*; #(
  parameter int FifoDepth = 16
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  uart_cfg_t            cfg_i,
  input  logic                 tx_we_i,
  input  logic [DataWidth-1:0] tx_wdata_i,
  input  logic                 rx_re_i,
  input  logic                 rx_i,
  output logic                 tx_o,
  output logic [DataWidth-1:0] rx_rdata_o,
  output uart_status_t         status_o,
  output uart_events_t         events_o
);

  localparam int LvlW = $clog2(FifoDepth + 1);

  logic                 tick_x16;
  logic                 tx_fifo_wready, tx_fifo_rvalid, tx_fifo_rready;
  logic [DataWidth-1:0] tx_fifo_rdata;
  logic [LvlW-1:0]      tx_depth, rx_depth;
  logic                 tx_idle, rx_idle;
  logic                 rx_push, rx_wready, rx_rvalid;
  logic [DataWidth-1:0] rx_data;
  logic                 rx_frame_err, rx_parity_err;

  uart_baud_gen u_baud_gen (
    .clk_i,
    .rst_ni,
    .enable_i   (cfg_i.tx_en | cfg_i.rx_en),
    .nco_i      (cfg_i.nco),
    .tick_x16_o (tick_x16)
  );

  ////////////////////////////////////////
  // transmit
  ////////////////////////////////////////
  uart_fifo #(.Width(DataWidth), .Depth(FifoDepth)) u_tx_fifo (
    .clk_i,
    .rst_ni,
    .wvalid_i (tx_we_i),
    .wdata_i  (tx_wdata_i),
    .rready_i (tx_fifo_rready),
    .wready_o (tx_fifo_wready),
    .depth_o  (tx_depth),
    .rvalid_o (tx_fifo_rvalid),
    .rdata_o  (tx_fifo_rdata)
  );

  uart_tx u_tx (
    .clk_i,
    .rst_ni,
    .tx_en_i       (cfg_i.tx_en),
    .tick_x16_i    (tick_x16),
    .parity_en_i   (cfg_i.parity_en),
    .parity_odd_i  (cfg_i.parity_odd),
    .fifo_rvalid_i (tx_fifo_rvalid),
    .fifo_rdata_i  (tx_fifo_rdata),
    .fifo_rready_o (tx_fifo_rready),
    .idle_o        (tx_idle),
    .tx_o
  );

  ////////////////////////////////////////
  // receive
  ////////////////////////////////////////
  uart_rx u_rx (
    .clk_i,
    .rst_ni,
    .rx_en_i      (cfg_i.rx_en),
    .nf_en_i      (cfg_i.nf_en),
    .tick_x16_i   (tick_x16),
    .parity_en_i  (cfg_i.parity_en),
    .parity_odd_i (cfg_i.parity_odd),
    .rx_i,
    .valid_o      (),
    .data_o       (rx_data),
    .frame_err_o  (rx_frame_err),
    .parity_err_o (rx_parity_err),
    .push_o       (rx_push),
    .idle_o       (rx_idle)
  );

  uart_fifo #(.Width(DataWidth), .Depth(FifoDepth)) u_rx_fifo (
    .clk_i,
    .rst_ni,
    .wvalid_i (rx_push),
    .wdata_i  (rx_data),
    .rready_i (rx_re_i),
    .wready_o (rx_wready),
    .depth_o  (rx_depth),
    .rvalid_o (rx_rvalid),
    .rdata_o  (rx_rdata_o)
  );

  uart_events #(.FifoDepth(FifoDepth)) u_events (
    .clk_i,
    .rst_ni,
    .rxilvl_i         (cfg_i.rxilvl),
    .rx_depth_i       (rx_depth),
    .rx_push_i        (rx_push),
    .rx_wready_i      (rx_wready),
    .rx_frame_err_i   (rx_frame_err),
    .rx_parity_err_i  (rx_parity_err),
    .tx_idle_i        (tx_idle),
    .tx_fifo_rvalid_i (tx_fifo_rvalid),
    .events_o
  );

  // tx counts as idle only once nothing is left to send
  assign status_o.tx_full  = ~tx_fifo_wready;
  assign status_o.tx_empty = ~tx_fifo_rvalid;
  assign status_o.tx_idle  = tx_idle & ~tx_fifo_rvalid;
  assign status_o.rx_full  = ~rx_wready;
  assign status_o.rx_empty = ~rx_rvalid;
  assign status_o.rx_idle  = rx_idle;
  assign status_o.tx_lvl   = 6'(tx_depth);
  assign status_o.rx_lvl   = 6'(rx_depth);

endmodule

//--- uart_tx.sv
/*
  Transmit serializer: start, 8 data bits LSB first, optional parity, stop.
  A byte is popped only on a baud tick while idle, so the start bit
  follows the pop by one cycle and every bit lasts exactly 16 ticks.
  Clearing tx_en_i aborts a frame in progress and idles the line high.
*/
`timescale 1ns/10ps

module uart_tx import uart_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 tx_en_i,
  input  logic                 tick_x16_i,
  input  logic                 parity_en_i,
  input  logic                 parity_odd_i,
  input  logic                 fifo_rvalid_i,
  input  logic [DataWidth-1:0] fifo_rdata_i,
  output logic                 fifo_rready_o,
  output logic                 idle_o,
  output logic                 tx_o
);

  uart_bit_state_e      state_q;
  logic [3:0]           cnt_q;
  logic [2:0]           bit_q;
  logic [DataWidth-1:0] shift_q;
  logic                 par_q;
  logic                 tx_q;
  logic                 bit_end;

  assign fifo_rready_o = tx_en_i & tick_x16_i & fifo_rvalid_i & (state_q == ST_IDLE);
  assign bit_end       = tick_x16_i & (cnt_q == 4'hf);

  ////////////////////////////////////////
  // bit phase fsm
  ////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
      bit_q   <= '0;
      tx_q    <= 1'b1;
    end else if (!tx_en_i) begin
      state_q <= ST_IDLE;
      tx_q    <= 1'b1;
    end else begin
      if (state_q != ST_IDLE && tick_x16_i) cnt_q <= cnt_q + 4'd1;
      unique case (state_q)
        ST_IDLE: begin
          if (fifo_rready_o) begin
            state_q <= ST_START;
            cnt_q   <= '0;
            bit_q   <= '0;
            tx_q    <= 1'b0;
          end
        end
        ST_START: begin
          if (bit_end) begin
            state_q <= ST_DATA;
            tx_q    <= shift_q[0];
          end
        end
        ST_DATA: begin
          if (bit_end) begin
            bit_q <= bit_q + 3'd1;
            if (bit_q == 3'd7) begin
              state_q <= parity_en_i ? ST_PARITY : ST_STOP;
              tx_q    <= parity_en_i ? par_q : 1'b1;
            end else begin
              tx_q <= shift_q[1];
            end
          end
        end
        ST_PARITY: begin
          if (bit_end) begin
            state_q <= ST_STOP;
            tx_q    <= 1'b1;
          end
        end
        ST_STOP: begin
          // line is already high, only the phase ends here
          if (bit_end) state_q <= ST_IDLE;
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // byte and parity latched at the pop, shifted out lsb first
  always_ff @(posedge clk_i) begin
    if (fifo_rready_o) begin
      shift_q <= fifo_rdata_i;
      par_q   <= (^fifo_rdata_i) ^ parity_odd_i;
    end else if (state_q == ST_DATA && bit_end) begin
      shift_q <= shift_q >> 1;
    end
  end

  assign idle_o = (state_q == ST_IDLE);
  assign tx_o   = tx_q;

  // every pop comes from idle and puts the start bit on the line next cycle
  a_pop_from_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fifo_rready_o |-> (state_q == ST_IDLE) ##1 (state_q == ST_START && !tx_o));

endmodule
